/* hdl/blur_pkg.sv */
`default_nettype none

package blur_pkg;

    // 12-bit unsigned grey pixel
    typedef logic [11:0] pixel_t;

    localparam int IMG_W = 15;
    localparam int IMG_H = 15;

    // Largest window edge and the edge of the small kernel
    localparam int WIN     = 5;
    localparam int K3_SIZE = 3;

    // Raster position counters
    typedef logic [$clog2(IMG_W)-1:0] col_t;
    typedef logic [$clog2(IMG_H)-1:0] row_t;

    // Code 3 is not named and falls back to bypass
    typedef enum logic [1:0] {
        MODE_BYPASS = 2'd0,
        MODE_K3     = 2'd1,
        MODE_K5     = 2'd2
    } blur_mode_t;

    // [0][0] is the oldest row and column, [WIN-1][WIN-1] the newest pixel
    typedef pixel_t [WIN-1:0][WIN-1:0] window_t;

    typedef logic [2:0] weight_t;

    // Holds 4095 * 64 without overflow
    localparam int ACC_W = 18;

    // Weight sum 32
    localparam weight_t [K3_SIZE-1:0][K3_SIZE-1:0] K3_WEIGHTS = '{
        '{3'd3, 3'd4, 3'd3},
        '{3'd4, 3'd4, 3'd4},
        '{3'd3, 3'd4, 3'd3}
    };

    // Weight sum 64
    localparam weight_t [WIN-1:0][WIN-1:0] K5_WEIGHTS = '{
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd3, 3'd4, 3'd4, 3'd4, 3'd3},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1}
    };

    // Divide by the weight sums
    localparam int K3_SHIFT = 5;
    localparam int K5_SHIFT = 6;

endpackage

`default_nettype wire

/* hdl/window_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface window_if;
    import blur_pkg::*;

    // Strobe, other fields only meaningful while it is high
    logic       valid;
    window_t    taps;
    blur_mode_t mode;
    // Window of the last pixel of the frame
    logic       eof;

    modport producer (
        output valid,
        output taps,
        output mode,
        output eof
    );

    modport consumer (
        input valid,
        input taps,
        input mode,
        input eof
    );

endinterface

`default_nettype wire

/* hdl/line_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module line_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pix_valid,
    input  logic                 pix_sof,
    input  blur_pkg::pixel_t     pix_data,
    input  blur_pkg::blur_mode_t mode,
    window_if.producer           win
);
    import blur_pkg::*;

    // Previous four rows, entry WIN-2 is the row just above
    pixel_t     row_mem [WIN-1][IMG_W];

    row_t       row_cnt;
    col_t       col_cnt;
    blur_mode_t mode_q;
    window_t    taps_q;

    row_t       cur_row;
    col_t       cur_col;
    blur_mode_t cur_mode;
    logic       last_pix;
    pixel_t     new_col [WIN];

    // Start of frame forces position (0,0) and takes the new mode
    always_comb begin
        cur_row  = pix_sof ? '0 : row_cnt;
        cur_col  = pix_sof ? '0 : col_cnt;
        cur_mode = pix_sof ? mode : mode_q;
        last_pix = (cur_row == row_t'(IMG_H - 1)) && (cur_col == col_t'(IMG_W - 1));
    end

    // New rightmost column, oldest row first
    always_comb begin
        new_col[WIN-1] = pix_data;
        for (int k = WIN - 2; k >= 0; k--) begin
            // Rows above the frame copy the row below, which ends up as row 0
            if (int'(cur_row) < WIN - 1 - k) begin
                new_col[k] = new_col[k+1];
            end else begin
                new_col[k] = row_mem[k][cur_col];
            end
        end
    end

    // Raster counters and mode capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
            col_cnt <= '0;
            mode_q  <= MODE_BYPASS;
        end else if (pix_valid) begin
            mode_q <= cur_mode;
            if (cur_col == col_t'(IMG_W - 1)) begin
                col_cnt <= '0;
                if (cur_row == row_t'(IMG_H - 1)) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= cur_row + 1'b1;
                end
            end else begin
                col_cnt <= cur_col + 1'b1;
                row_cnt <= cur_row;
            end
        end
    end

    // Each column of the row memories moves up by one row per write
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            for (int k = 0; k < WIN - 2; k++) begin
                row_mem[k][cur_col] <= row_mem[k+1][cur_col];
            end
            row_mem[WIN-2][cur_col] <= pix_data;
        end
    end

    // Window shifts left, at column 0 every column gets the new one
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            for (int i = 0; i < WIN; i++) begin
                for (int j = 0; j < WIN - 1; j++) begin
                    if (cur_col == '0) begin
                        taps_q[i][j] <= new_col[i];
                    end else begin
                        taps_q[i][j] <= taps_q[i][j+1];
                    end
                end
                taps_q[i][WIN-1] <= new_col[i];
            end
        end
    end

    // Control towards the arithmetic stage, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win.valid <= 1'b0;
            win.eof   <= 1'b0;
            win.mode  <= MODE_BYPASS;
        end else begin
            win.valid <= pix_valid;
            win.eof   <= pix_valid && last_pix;
            if (pix_valid) begin
                win.mode <= cur_mode;
            end
        end
    end

    assign win.taps = taps_q;

endmodule

`default_nettype wire

/* hdl/blur_mac.sv */
`default_nettype none
`timescale 1ns/100ps

module blur_mac (
    input  logic             clk,
    input  logic             rst_n,
    window_if.consumer       win,
    output logic             out_valid,
    output logic             out_eof,
    output blur_pkg::pixel_t out_data
);
    import blur_pkg::*;

    typedef logic [ACC_W-1:0] acc_t;

    acc_t       k3_row   [K3_SIZE];
    acc_t       k5_row   [WIN];
    acc_t       k3_row_q [K3_SIZE];
    acc_t       k5_row_q [WIN];
    logic       valid_q;
    logic       eof_q;
    blur_mode_t mode_q;
    pixel_t     newest_q;

    acc_t       k3_sum;
    acc_t       k5_sum;
    pixel_t     k3_pix;
    pixel_t     k5_pix;
    pixel_t     sel_pix;

    // Stage one row sums, both kernels
    always_comb begin
        for (int i = 0; i < WIN; i++) begin
            k5_row[i] = '0;
            for (int j = 0; j < WIN; j++) begin
                k5_row[i] = k5_row[i] + acc_t'(win.taps[i][j]) * acc_t'(K5_WEIGHTS[i][j]);
            end
        end
        // Small kernel sits in the newest corner of the window
        for (int i = 0; i < K3_SIZE; i++) begin
            k3_row[i] = '0;
            for (int j = 0; j < K3_SIZE; j++) begin
                k3_row[i] = k3_row[i]
                    + acc_t'(win.taps[WIN-K3_SIZE+i][WIN-K3_SIZE+j])
                    * acc_t'(K3_WEIGHTS[i][j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            eof_q   <= 1'b0;
            mode_q  <= MODE_BYPASS;
        end else begin
            valid_q <= win.valid;
            eof_q   <= win.valid && win.eof;
            if (win.valid) begin
                mode_q <= win.mode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            k3_row_q <= k3_row;
            k5_row_q <= k5_row;
            newest_q <= win.taps[WIN-1][WIN-1];
        end
    end

    // Stage two totals and normalization
    always_comb begin
        k3_sum = '0;
        for (int i = 0; i < K3_SIZE; i++) begin
            k3_sum = k3_sum + k3_row_q[i];
        end
        k5_sum = '0;
        for (int i = 0; i < WIN; i++) begin
            k5_sum = k5_sum + k5_row_q[i];
        end
        // Weight sums are powers of two, so the shift leaves 12 bits
        k3_pix = pixel_t'(k3_sum >> K3_SHIFT);
        k5_pix = pixel_t'(k5_sum >> K5_SHIFT);
        case (mode_q)
            MODE_K3: sel_pix = k3_pix;
            MODE_K5: sel_pix = k5_pix;
            default: sel_pix = newest_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_eof   <= 1'b0;
        end else begin
            out_valid <= valid_q;
            out_eof   <= eof_q;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            out_data <= sel_pix;
        end
    end

endmodule

`default_nettype wire

/* hdl/blur_filter_top.sv */
`default_nettype none
`timescale 1ns/100ps

module blur_filter_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pix_valid,
    input  logic                 pix_sof,
    input  blur_pkg::pixel_t     pix_data,
    input  blur_pkg::blur_mode_t mode,
    output logic                 out_valid,
    output logic                 out_eof,
    output blur_pkg::pixel_t     out_data
);

    // Window plus control, one cycle behind the input strobe
    window_if win ();

    line_buffer i_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_data  (pix_data),
        .mode      (mode),
        .win       (win)
    );

    // Two more cycles to the output pixel
    blur_mac i_blur_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win),
        .out_valid (out_valid),
        .out_eof   (out_eof),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* bench/tb_blur_filter.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_blur_filter;
    import blur_pkg::*;

    // About one and a half times the length of all frames with their gaps
    localparam int MAX_CYCLES = 4000;
    localparam int FRAME_PIX  = IMG_W * IMG_H;

    logic       clk;
    logic       rst_n;
    logic       pix_valid;
    logic       pix_sof;
    pixel_t     pix_data;
    blur_mode_t mode;
    logic       out_valid;
    logic       out_eof;
    pixel_t     out_data;

    // Reference model state
    pixel_t     frame [IMG_H][IMG_W];
    int         mdl_row;
    int         mdl_col;
    blur_mode_t mdl_mode;
    pixel_t     exp_pix [$];
    logic       exp_eof [$];

    // Constant that every output must equal during the flat frames
    logic       flat_on    = 1'b0;
    pixel_t     flat_level = '0;

    string      test_name;
    int         cycle_cnt = 0;
    int         in_count  = 0;
    int         out_count = 0;

    blur_filter_top i_blur_filter_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_data  (pix_data),
        .mode      (mode),
        .out_valid (out_valid),
        .out_eof   (out_eof),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    // Clamped causal window where rows and columns below 0 read index 0
    function automatic pixel_t model_pixel(input int r, input int c, input blur_mode_t m);
        int k;
        int shift;
        int sum;
        int rr;
        int cc;
        int w;
        if (m == MODE_K3) begin
            k = 3;
            shift = K3_SHIFT;
        end else if (m == MODE_K5) begin
            k = 5;
            shift = K5_SHIFT;
        end else begin
            return frame[r][c];
        end
        sum = 0;
        for (int i = 0; i < k; i++) begin
            for (int j = 0; j < k; j++) begin
                rr = (r - k + 1 + i < 0) ? 0 : r - k + 1 + i;
                cc = (c - k + 1 + j < 0) ? 0 : c - k + 1 + j;
                w = (k == 3) ? int'(K3_WEIGHTS[i][j]) : int'(K5_WEIGHTS[i][j]);
                sum += w * int'(frame[rr][cc]);
            end
        end
        return pixel_t'(sum >> shift);
    endfunction

    // Called and returns on a falling edge
    task automatic send_pixel(input pixel_t value, input logic sof, input blur_mode_t m,
                              input int gap);
        pix_valid = 1'b1;
        pix_sof   = sof;
        pix_data  = value;
        mode      = m;
        if (sof) begin
            mdl_row  = 0;
            mdl_col  = 0;
            mdl_mode = m;
        end
        frame[mdl_row][mdl_col] = value;
        exp_pix.push_back(model_pixel(mdl_row, mdl_col, mdl_mode));
        exp_eof.push_back(mdl_row == IMG_H - 1 && mdl_col == IMG_W - 1);
        in_count++;
        if (mdl_col == IMG_W - 1) begin
            mdl_col = 0;
            mdl_row = (mdl_row == IMG_H - 1) ? 0 : mdl_row + 1;
        end else begin
            mdl_col++;
        end
        @(negedge clk);
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // Mode pin switches to late_mode halfway through the frame
    task automatic run_frame(input blur_mode_t frame_mode, input blur_mode_t late_mode,
                             input int npix, input int max_gap, input logic flat,
                             input pixel_t flat_val);
        pixel_t     value;
        blur_mode_t m;
        int         gap;
        for (int idx = 0; idx < npix; idx++) begin
            value = flat ? flat_val : pixel_t'($urandom);
            m     = (idx < FRAME_PIX / 2) ? frame_mode : late_mode;
            gap   = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            send_pixel(value, idx == 0, m, gap);
        end
    endtask

    task automatic drain;
        while (exp_pix.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Output strobe exactly three cycles after the input strobe
    assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(pix_valid, 3))
        else fail_run("output strobe is not three cycles after its input strobe");

    assert property (@(posedge clk) disable iff (!rst_n) out_eof |-> out_valid)
        else fail_run("end of frame flag without an output strobe");

    always @(posedge clk) begin
        pixel_t exp_p;
        logic   exp_e;
        if (rst_n && out_valid) begin
            if (exp_pix.size() == 0) begin
                fail_run("output strobe without pending pixel");
            end else begin
                exp_p = exp_pix.pop_front();
                exp_e = exp_eof.pop_front();
                assert (out_data === exp_p)
                    else fail_run($sformatf(
                        "** Error [%s] output %0d: expected %0d, actual %0d",
                        test_name, out_count, exp_p, out_data));
                assert (out_eof === exp_e)
                    else fail_run($sformatf(
                        "** Error [%s] eof at output %0d: expected %0b, actual %0b",
                        test_name, out_count, exp_e, out_eof));
                if (flat_on) begin
                    assert (out_data === flat_level)
                        else fail_run($sformatf(
                            "** Error [%s] flat output %0d: expected %0d, actual %0d",
                            test_name, out_count, flat_level, out_data));
                end
                out_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run("timeout, the run did not finish in time");
        end
    end

    initial begin
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
        pix_data  = '0;
        mode      = MODE_BYPASS;
        mdl_row   = 0;
        mdl_col   = 0;
        mdl_mode  = MODE_BYPASS;
        void'($urandom(32'h1041c854));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_name = "bypass_frame";
        run_frame(MODE_BYPASS, MODE_BYPASS, FRAME_PIX, 0, 1'b0, '0);
        drain();

        test_name = "blur3_frame";
        run_frame(MODE_K3, MODE_K3, FRAME_PIX, 0, 1'b0, '0);
        drain();

        test_name = "blur5_frame";
        run_frame(MODE_K5, MODE_K5, FRAME_PIX, 3, 1'b0, '0);
        drain();

        // Constant input must come out unchanged from both kernels
        test_name = "flat_frame";
        flat_level = pixel_t'($urandom);
        flat_on = 1'b1;
        run_frame(MODE_K3, MODE_K3, FRAME_PIX, 0, 1'b1, flat_level);
        run_frame(MODE_K5, MODE_K5, FRAME_PIX, 1, 1'b1, flat_level);
        drain();
        flat_on = 1'b0;

        test_name = "mode_hold";
        run_frame(MODE_K3, MODE_K5, FRAME_PIX, 0, 1'b0, '0);
        run_frame(MODE_K5, MODE_BYPASS, FRAME_PIX, 0, 1'b0, '0);
        drain();

        // Abandoned frame stops in row 6
        test_name = "early_sof";
        run_frame(MODE_K5, MODE_K5, 100, 2, 1'b0, '0);
        run_frame(MODE_K3, MODE_K3, FRAME_PIX, 0, 1'b0, '0);
        drain();

        repeat (4) @(negedge clk);
        if (out_count == in_count) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("number of outputs differs from number of inputs");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/blur_pkg.sv
hdl/window_if.sv
hdl/line_buffer.sv
hdl/blur_mac.sv
hdl/blur_filter_top.sv
bench/tb_blur_filter.sv

/* Bender.yml */
package:
  name: blur_filter

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - hdl/blur_pkg.sv
      - hdl/window_if.sv
      - hdl/line_buffer.sv
      - hdl/blur_mac.sv
      - hdl/blur_filter_top.sv

  # Testbench
  - target: test
    files:
      - bench/tb_blur_filter.sv

# Top modules: blur_filter_top, tb_blur_filter
